//--- files.f
hw/cpu_pkg.sv
hw/cpu_alu.sv
hw/cpu_exec.sv
hw/cpu_control.sv
hw/serial_cpu.sv
testbench/serial_cpu_assert.sv
testbench/tb_serial_cpu.sv

//--- Makefile
TOP  = tb_serial_cpu
MDIR = obj_dir

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f files.f --Mdir $(MDIR) -o $(TOP)
	./$(MDIR)/$(TOP) | tee sim.log
	grep -q -F "*** TEST PASSED ***" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf $(MDIR) sim.log

//--- testbench/tb_serial_cpu.sv
// ----------------------------------------
// serial cpu testbench running random
// programs against an instruction-level model
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_serial_cpu;
    import cpu_pkg::*;

    localparam int PC_WIDTH   = 9;
    localparam int NUM_WORDS  = 1 << PC_WIDTH;
    localparam int PROG_LEN   = 40;
    localparam int NUM_PROGS  = 12;
    // fetch hi, fetch lo, decode, execute, mem lo, mem hi, writeback
    localparam int CYCLES_PER_INSTR = 7;
    localparam int MAX_CYCLES = 8 * 41 * NUM_PROGS + 8 * NUM_WORDS + 1000;
    localparam word_t NOP_WORD  = {op_nop, 11'h000};
    localparam word_t HALT_WORD = {op_halt, 11'h000};

    logic                clk;
    logic                rst_n;
    logic                start;
    logic [PC_WIDTH:0]   i_addr;
    byte_t               i_data;
    logic [PC_WIDTH:0]   d_addr;
    byte_t               d_rdata;
    byte_t               d_wdata;
    logic                d_we;
    logic                busy;
    run_status_e         run_status;

    byte_t  imem [2*NUM_WORDS];
    byte_t  dmem [2*NUM_WORDS];
    word_t  prog [NUM_WORDS];

    // model state persists across runs like the cpu's
    byte_t  ref_mem [2*NUM_WORDS];
    word_t  ref_gr [8];
    flags_t ref_flags;
    word_t  exp_addr [$];
    byte_t  exp_data [$];

    integer seed;
    int     cycle_cnt = 0;
    int     errors;
    logic   reported;

    serial_cpu #(
        .PC_WIDTH (PC_WIDTH)
    ) i_serial_cpu (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .i_addr     (i_addr),
        .i_data     (i_data),
        .d_addr     (d_addr),
        .d_rdata    (d_rdata),
        .d_wdata    (d_wdata),
        .d_we       (d_we),
        .busy       (busy),
        .run_status (run_status)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // byte memories with combinational read
    assign i_data  = imem[i_addr];
    assign d_rdata = dmem[d_addr];

    always @(posedge clk)
    begin
        if (d_we)
            dmem[d_addr] <= d_wdata;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("simulation ran past %0d cycles without finishing", MAX_CYCLES);
            report_failure();
        end
    end

    // ----------------------------------------
    // result checks
    // ----------------------------------------
    task automatic report_failure();
        errors   = errors + 1;
        reported = 1'b1;
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_status(input string name, input run_status_e got,
                                input run_status_e exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            report_failure();
        end
    endtask

    // every write must be the next byte the model stored
    always @(negedge clk)
    begin
        if (rst_n && d_we)
        begin
            if (exp_addr.size() == 0)
            begin
                $display("data memory write at %h that the model never stored", d_addr);
                report_failure();
            end
            else
            begin
                check_word("d_addr", word_t'(d_addr), exp_addr.pop_front());
                check_byte("d_wdata", d_wdata, exp_data.pop_front());
            end
        end
    end

    // ----------------------------------------
    // program generation
    // ----------------------------------------
    // r0 is never a destination and branch targets only point forward
    task automatic gen_instr(input int addr, input int last, output word_t w);
        instr_t ins;
        int     k;
        int     span;
        k      = {$random(seed)} % 23;
        ins.r1 = reg_idx_t'(1 + {$random(seed)} % 7);
        ins.r2 = 4'($random(seed));
        ins.r3 = 4'($random(seed));
        if (k < 20)
            ins.op = opcode_e'(5'(k + 8));
        else if (k == 20)
            ins.op = op_nop;
        else if (k == 21)
            ins.op = op_load;
        else
            ins.op = op_store;
        case (ins.op)
            op_cmp, op_store:
                ins.r1 = reg_idx_t'($random(seed));
            op_jump, op_jmpr, op_bz, op_bnz, op_bn, op_bnn, op_bc, op_bnc:
            begin
                span = last - addr;
                {ins.r2, ins.r3} = 8'(addr + 1 + {$random(seed)} % span);
                ins.r1 = '0;
            end
            default: ;
        endcase
        w = word_t'(ins);
    endtask

    task automatic load_program(input int len, input logic with_halt);
        int i;
        for (i = 0; i < NUM_WORDS; i++)
            prog[i] = NOP_WORD;
        for (i = 0; i < len - 1; i++)
            gen_instr(i, len - 1, prog[i]);
        if (with_halt)
            prog[len-1] = HALT_WORD;
        for (i = 0; i < NUM_WORDS; i++)
        begin
            imem[2*i]   = prog[i][15:8];
            imem[2*i+1] = prog[i][7:0];
        end
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    task automatic run_model(output int n_exec, output run_status_e status);
        instr_t ins;
        byte_t  imm8;
        word_t  a;
        word_t  b;
        word_t  res;
        logic   c;
        logic   taken;
        logic   done;
        int     pc;
        int     wa;
        pc     = 0;
        n_exec = 0;
        status = rs_none;
        done   = 1'b0;
        while (!done)
        begin
            ins    = instr_t'(prog[pc]);
            imm8   = {ins.r2, ins.r3};
            n_exec = n_exec + 1;
            case (ins.op)
                op_addi, op_subi, op_ldih, op_jmpr,
                op_bz, op_bnz, op_bn, op_bnn, op_bc, op_bnc:
                    a = ref_gr[ins.r1];
                op_jump, op_set, op_nop, op_halt:
                    a = '0;
                default:
                    a = ref_gr[ins.r2[2:0]];
            endcase
            case (ins.op)
                op_add, op_sub, op_cmp, op_and, op_or, op_xor:
                    b = ref_gr[ins.r3[2:0]];
                op_load, op_store, op_sll, op_srl:
                    b = word_t'(ins.r3);
                op_ldih:
                    b = {imm8, 8'h00};
                op_nop, op_halt:
                    b = '0;
                default:
                    b = word_t'(imm8);
            endcase
            c = 1'b0;
            case (ins.op)
                op_sub, op_subi, op_cmp: {c, res} = {1'b0, a} - {1'b0, b};
                op_and:                  res = a & b;
                op_or:                   res = a | b;
                op_xor:                  res = a ^ b;
                op_sll:                  res = a << b[3:0];
                op_srl:                  res = a >> b[3:0];
                op_set, op_jump:         res = b;
                default:                 {c, res} = {1'b0, a} + {1'b0, b};
            endcase
            case (ins.op)
                op_add, op_addi, op_sub, op_subi, op_cmp, op_ldih,
                op_and, op_or, op_xor, op_sll, op_srl:
                begin
                    ref_flags.zf = (res == 16'h0000);
                    ref_flags.nf = res[15];
                    // shifts leave carry alone
                    if (ins.op != op_sll && ins.op != op_srl)
                        ref_flags.cf = c;
                end
                default: ;
            endcase
            wa = int'(res[PC_WIDTH-1:0]);
            case (ins.op)
                op_store:
                begin
                    ref_mem[2*wa]   = ref_gr[ins.r1][15:8];
                    ref_mem[2*wa+1] = ref_gr[ins.r1][7:0];
                    exp_addr.push_back(word_t'(2 * wa));
                    exp_data.push_back(ref_gr[ins.r1][15:8]);
                    exp_addr.push_back(word_t'(2 * wa + 1));
                    exp_data.push_back(ref_gr[ins.r1][7:0]);
                end
                op_load:
                    ref_gr[ins.r1] = {ref_mem[2*wa], ref_mem[2*wa+1]};
                op_add, op_addi, op_sub, op_subi, op_and, op_or, op_xor,
                op_sll, op_srl, op_ldih, op_set:
                    ref_gr[ins.r1] = res;
                default: ;
            endcase
            case (ins.op)
                op_jump, op_jmpr: taken = 1'b1;
                op_bz:            taken = ref_flags.zf;
                op_bnz:           taken = !ref_flags.zf;
                op_bn:            taken = ref_flags.nf;
                op_bnn:           taken = !ref_flags.nf;
                op_bc:            taken = ref_flags.cf;
                op_bnc:           taken = !ref_flags.cf;
                default:          taken = 1'b0;
            endcase
            if (ins.op == op_halt)
            begin
                status = rs_halted;
                done   = 1'b1;
            end
            else if (taken)
                pc = wa;
            else if (pc == NUM_WORDS - 1)
            begin
                status = rs_end_of_program;
                done   = 1'b1;
            end
            else
                pc = pc + 1;
        end
    endtask

    // start one run and compare everything once busy drops
    task automatic run_program();
        run_status_e exp_status;
        int          n_exec;
        int          cycles;
        int          i;
        run_model(n_exec, exp_status);
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_bit("busy", busy, 1'b1);
        cycles = 0;
        while (busy)
        begin
            cycles = cycles + 1;
            @(negedge clk);
        end
        check_status("run_status", run_status, exp_status);
        check_word("cycles", word_t'(cycles), word_t'(CYCLES_PER_INSTR * n_exec));
        if (exp_addr.size() != 0)
        begin
            $display("%0d model store bytes never reached the data memory",
                     exp_addr.size());
            report_failure();
        end
        for (i = 0; i < 2 * NUM_WORDS; i++)
            check_byte($sformatf("dmem[%0d]", i), dmem[i], ref_mem[i]);
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial
    begin
        byte_t v;
        int    i;
        seed      = 35940;
        errors    = 0;
        reported  = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        ref_flags = '0;
        for (i = 0; i < 8; i++)
            ref_gr[i] = '0;
        for (i = 0; i < 2 * NUM_WORDS; i++)
        begin
            v          = 8'($random(seed));
            dmem[i]   <= v;
            ref_mem[i] = v;
            imem[i]    = 8'h00;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("busy", busy, 1'b0);
        check_bit("d_we", d_we, 1'b0);
        check_status("run_status", run_status, rs_none);
        for (i = 0; i < NUM_PROGS; i++)
        begin
            load_program(PROG_LEN, 1'b1);
            run_program();
        end
        // program without halt runs through the last word address
        load_program(PROG_LEN, 1'b0);
        run_program();
        reported = 1'b1;
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // run stopped before the end of the sequence
    final
    begin
        if (!reported)
            $display("*** TEST FAILED ***");
    end

endmodule

`default_nettype wire

//--- testbench/serial_cpu_assert.sv
// ----------------------------------------
// port protocol assertions for serial_cpu
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module serial_cpu_assert #(
    parameter int PC_WIDTH = 9
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic [PC_WIDTH:0]    i_addr,
    input logic                 d_we,
    input logic                 busy,
    input cpu_pkg::run_status_e run_status
);
    import cpu_pkg::*;

    // stores only inside a run
    we_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        d_we |-> busy)
        else $error("d_we high while the cpu is idle");

    // a run ends together with its status
    run_end_status: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> (run_status != rs_none) && ($past(run_status) == rs_none))
        else $error("busy fell without a new run status");

    // low fetch byte address holds until the next fetch
    fetch_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (busy && i_addr[0]) |=> (!i_addr[0] || $stable(i_addr)))
        else $error("i_addr moved outside a fetch");

    // one store is exactly two byte writes
    store_second_byte: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(d_we) |=> d_we)
        else $error("d_we high for only one cycle");

    store_no_third: assert property (@(posedge clk) disable iff (!rst_n)
        (d_we && $past(d_we)) |=> !d_we)
        else $error("d_we high for more than two cycles");

endmodule

bind serial_cpu serial_cpu_assert #(
    .PC_WIDTH (PC_WIDTH)
) i_serial_cpu_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_addr     (i_addr),
    .d_we       (d_we),
    .busy       (busy),
    .run_status (run_status)
);

`default_nettype wire

//--- hw/serial_cpu.sv
// ----------------------------------------
// serial 16-bit cpu with byte-wide buses
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module serial_cpu #(
    parameter int PC_WIDTH = 9
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    output logic [PC_WIDTH:0]    i_addr,
    input  cpu_pkg::byte_t       i_data,
    output logic [PC_WIDTH:0]    d_addr,
    input  cpu_pkg::byte_t       d_rdata,
    output cpu_pkg::byte_t       d_wdata,
    output logic                 d_we,
    output logic                 busy,
    output cpu_pkg::run_status_e run_status
);
    import cpu_pkg::*;

    cpu_state_e          state;
    instr_t              ir;
    logic                branch_taken;
    logic [PC_WIDTH-1:0] target;

    // sequencer, pc and instruction fetch
    cpu_control #(
        .PC_WIDTH (PC_WIDTH)
    ) i_cpu_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .i_data       (i_data),
        .branch_taken (branch_taken),
        .target       (target),
        .i_addr       (i_addr),
        .state        (state),
        .ir           (ir),
        .busy         (busy),
        .run_status   (run_status)
    );

    // datapath and data memory port
    cpu_exec #(
        .PC_WIDTH (PC_WIDTH)
    ) i_cpu_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .state        (state),
        .ir           (ir),
        .d_rdata      (d_rdata),
        .d_addr       (d_addr),
        .d_wdata      (d_wdata),
        .d_we         (d_we),
        .branch_taken (branch_taken),
        .target       (target)
    );

endmodule

`default_nettype wire

//--- hw/cpu_control.sv
// ----------------------------------------
// state sequencer, program counter and
// instruction fetch over the byte bus
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cpu_control #(
    parameter int PC_WIDTH = 9
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  cpu_pkg::byte_t       i_data,
    input  logic                 branch_taken,
    input  logic [PC_WIDTH-1:0]  target,
    output logic [PC_WIDTH:0]    i_addr,
    output cpu_pkg::cpu_state_e  state,
    output cpu_pkg::instr_t      ir,
    output logic                 busy,
    output cpu_pkg::run_status_e run_status
);
    import cpu_pkg::*;

    cpu_state_e          state_nxt;
    logic [PC_WIDTH-1:0] pc;
    logic                pc_last;
    logic                is_halt;

    assign pc_last = (pc == {PC_WIDTH{1'b1}});
    assign is_halt = (ir.op == op_halt);
    assign busy    = (state != st_idle);

    // high byte at the even address, then the low byte
    assign i_addr = {pc, (state != st_fetch_hi)};

    // ----------------------------------------
    // state sequence
    // ----------------------------------------
    always_comb
    begin
        state_nxt = state;
        case (state)
            st_idle:
                if (start)
                    state_nxt = st_fetch_hi;
            st_fetch_hi:
                state_nxt = st_fetch_lo;
            st_fetch_lo:
                state_nxt = st_decode;
            st_decode:
                state_nxt = st_execute;
            st_execute:
                state_nxt = st_mem_lo;
            st_mem_lo:
                state_nxt = st_mem_hi;
            st_mem_hi:
                state_nxt = st_writeback;
            st_writeback:
            begin
                if (is_halt)
                    state_nxt = st_idle;
                else if (branch_taken)
                    state_nxt = st_fetch_hi;
                else if (pc_last)
                    state_nxt = st_idle;
                else
                    state_nxt = st_fetch_hi;
            end
            default:
                state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    // ----------------------------------------
    // pc and run status
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc         <= '0;
            run_status <= rs_none;
        end
        else if (state == st_idle && start)
        begin
            pc         <= '0;
            run_status <= rs_none;
        end
        else if (state == st_writeback)
        begin
            if (is_halt)
                run_status <= rs_halted;
            else if (branch_taken)
                pc <= target;
            else if (pc_last)
                run_status <= rs_end_of_program;
            else
                pc <= pc + 1'b1;
        end
    end

    // instruction register, assembled one byte per fetch state
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ir <= '{op: op_nop, r1: '0, r2: '0, r3: '0};
        else if (state == st_fetch_hi)
            ir <= instr_t'({i_data, ir[7:0]});
        else if (state == st_fetch_lo)
            ir <= instr_t'({ir[15:8], i_data});
    end

endmodule

`default_nettype wire

//--- hw/cpu_exec.sv
// ----------------------------------------
// register file, operands, flags, branch
// test and data memory byte transfers
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cpu_exec #(
    parameter int PC_WIDTH = 9
) (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::cpu_state_e state,
    input  cpu_pkg::instr_t     ir,
    input  cpu_pkg::byte_t      d_rdata,
    output logic [PC_WIDTH:0]   d_addr,
    output cpu_pkg::byte_t      d_wdata,
    output logic                d_we,
    output logic                branch_taken,
    output logic [PC_WIDTH-1:0] target
);
    import cpu_pkg::*;

    word_t    gr [8];
    word_t    a_q;
    word_t    b_q;
    word_t    smdr;
    word_t    res_q;
    word_t    ld_word;
    word_t    a_nxt;
    word_t    b_nxt;
    word_t    alu_res;
    logic     alu_carry;
    flags_t   flags;
    reg_idx_t r2_idx;
    reg_idx_t r3_idx;
    byte_t    imm8;
    logic     mem_phase;

    assign r2_idx = ir.r2[2:0];
    assign r3_idx = ir.r3[2:0];
    assign imm8   = {ir.r2, ir.r3};

    // ----------------------------------------
    // operand selection for decode
    // ----------------------------------------
    always_comb
    begin
        case (ir.op)
            op_addi, op_subi, op_ldih, op_jmpr,
            op_bz, op_bnz, op_bn, op_bnn, op_bc, op_bnc:
                a_nxt = gr[ir.r1];
            op_load, op_store, op_add, op_sub, op_cmp,
            op_and, op_or, op_xor, op_sll, op_srl:
                a_nxt = gr[r2_idx];
            default:
                a_nxt = '0;
        endcase

        case (ir.op)
            op_add, op_sub, op_cmp, op_and, op_or, op_xor:
                b_nxt = gr[r3_idx];
            op_load, op_store, op_sll, op_srl:
                b_nxt = {12'b0, ir.r3};
            op_addi, op_subi, op_set, op_jump, op_jmpr,
            op_bz, op_bnz, op_bn, op_bnn, op_bc, op_bnc:
                b_nxt = {8'b0, imm8};
            op_ldih:
                b_nxt = {imm8, 8'b0};
            default:
                b_nxt = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (state == st_decode)
        begin
            a_q  <= a_nxt;
            b_q  <= b_nxt;
            smdr <= gr[ir.r1];
        end
        if (state == st_execute)
            res_q <= alu_res;
        // load data arrives high byte first
        if (state == st_mem_lo)
            ld_word[15:8] <= d_rdata;
        if (state == st_mem_hi)
            ld_word[7:0] <= d_rdata;
    end

    cpu_alu i_cpu_alu (
        .op     (ir.op),
        .a      (a_q),
        .b      (b_q),
        .result (alu_res),
        .carry  (alu_carry)
    );

    // flags follow arithmetic, logic and shift results
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            flags <= '0;
        else if (state == st_execute)
        begin
            case (ir.op)
                op_add, op_addi, op_sub, op_subi, op_cmp, op_ldih:
                    flags <= '{zf: (alu_res == '0), nf: alu_res[15], cf: alu_carry};
                op_and, op_or, op_xor:
                    flags <= '{zf: (alu_res == '0), nf: alu_res[15], cf: 1'b0};
                op_sll, op_srl:
                    flags <= '{zf: (alu_res == '0), nf: alu_res[15], cf: flags.cf};
                default:
                    flags <= flags;
            endcase
        end
    end

    // ----------------------------------------
    // data memory port and branch decision
    // ----------------------------------------
    assign mem_phase = (state == st_mem_hi);
    assign d_addr    = {res_q[PC_WIDTH-1:0], mem_phase};
    assign d_wdata   = mem_phase ? smdr[7:0] : smdr[15:8];
    assign d_we      = (ir.op == op_store) &&
                       (state == st_mem_lo || state == st_mem_hi);
    assign target    = res_q[PC_WIDTH-1:0];

    always_comb
    begin
        case (ir.op)
            op_jump, op_jmpr: branch_taken = 1'b1;
            op_bz:            branch_taken = flags.zf;
            op_bnz:           branch_taken = !flags.zf;
            op_bn:            branch_taken = flags.nf;
            op_bnn:           branch_taken = !flags.nf;
            op_bc:            branch_taken = flags.cf;
            op_bnc:           branch_taken = !flags.cf;
            default:          branch_taken = 1'b0;
        endcase
    end

    // register file writeback
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 8; i++)
                gr[i] <= '0;
        end
        else if (state == st_writeback)
        begin
            case (ir.op)
                op_load:
                    gr[ir.r1] <= ld_word;
                op_add, op_addi, op_sub, op_subi, op_and, op_or, op_xor,
                op_sll, op_srl, op_ldih, op_set:
                    gr[ir.r1] <= res_q;
                default:
                    gr[ir.r1] <= gr[ir.r1];
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/cpu_alu.sv
// ----------------------------------------
// combinational alu with carry out
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
    input  cpu_pkg::opcode_e op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   result,
    output logic             carry
);
    import cpu_pkg::*;

    logic [16:0] sum;
    logic [16:0] diff;
    logic [16:0] ext;

    // 17th bit is carry for add, borrow for subtract
    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};

    always_comb
    begin
        case (op)
            op_sub, op_subi, op_cmp:
                ext = diff;
            op_and:
                ext = {1'b0, a & b};
            op_or:
                ext = {1'b0, a | b};
            op_xor:
                ext = {1'b0, a ^ b};
            op_sll:
                ext = {1'b0, a << b[3:0]};
            op_srl:
                ext = {1'b0, a >> b[3:0]};
            op_set, op_jump:
                ext = {1'b0, b};
            // add, addi, ldih, address and branch target sums
            default:
                ext = sum;
        endcase
    end

    assign result = ext[15:0];
    assign carry  = ext[16];

endmodule

`default_nettype wire

//--- hw/cpu_pkg.sv
// ----------------------------------------
// serial cpu shared types: widths, opcodes,
// instruction layout, flags and run states
// ----------------------------------------
`default_nettype none

package cpu_pkg;

    localparam int WORD_W = 16;
    localparam int BYTE_W = 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [2:0]        reg_idx_t;

    // opcode field, top 5 bits of every instruction
    typedef enum logic [4:0] {
        op_nop   = 5'd0,
        op_halt  = 5'd1,
        op_load  = 5'd2,
        op_store = 5'd3,
        op_ldih  = 5'd8,
        op_add   = 5'd9,
        op_addi  = 5'd10,
        op_sub   = 5'd11,
        op_subi  = 5'd12,
        op_cmp   = 5'd13,
        op_and   = 5'd14,
        op_or    = 5'd15,
        op_xor   = 5'd16,
        op_sll   = 5'd17,
        op_srl   = 5'd18,
        op_set   = 5'd19,
        op_jump  = 5'd20,
        op_jmpr  = 5'd21,
        op_bz    = 5'd22,
        op_bnz   = 5'd23,
        op_bn    = 5'd24,
        op_bnn   = 5'd25,
        op_bc    = 5'd26,
        op_bnc   = 5'd27
    } opcode_e;

    // r2 and r3 are 4-bit fields; the low 3 bits name a register,
    // {r2, r3} together form imm8 and r3 alone is val3
    typedef struct packed {
        opcode_e    op;
        reg_idx_t   r1;
        logic [3:0] r2;
        logic [3:0] r3;
    } instr_t;

    typedef struct packed {
        logic zf;
        logic nf;
        logic cf;
    } flags_t;

    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_fetch_hi  = 3'd1,
        st_fetch_lo  = 3'd2,
        st_decode    = 3'd3,
        st_execute   = 3'd4,
        st_mem_lo    = 3'd5,
        st_mem_hi    = 3'd6,
        st_writeback = 3'd7
    } cpu_state_e;

    typedef enum logic [1:0] {
        rs_none           = 2'd0,
        rs_halted         = 2'd1,
        rs_end_of_program = 2'd2
    } run_status_e;

endpackage

`default_nettype wire
